// ==== hw/video_pkg.sv ====
// video mode decoder package: mode encodings, raster geometry and dram bandwidth tables
`default_nettype none

package video_pkg;

	localparam int VADDR_W = 21; // dram word address

	// video mode, vconf[1:0]
	typedef enum logic [1:0] {
		M_ZX = 2'd0, // zx screen
		M_HC = 2'd1, // 16 colour
		M_XC = 2'd2, // 256 colour
		M_TX = 2'd3  // text
	} vmode_t;

	// render mode seen by the renderer
	typedef enum logic [1:0] {
		R_ZX = 2'd0,
		R_HC = 2'd1,
		R_XC = 2'd2,
		R_TX = 2'd3
	} render_t;

	// raster resolution, vconf[7:6]
	typedef enum logic [1:0] {
		RRES_256  = 2'd0,
		RRES_320A = 2'd1,
		RRES_320B = 2'd2,
		RRES_360  = 2'd3
	} rres_t;

	// [4:3] total cycles 00=2 01=4 11=8, [2:0] cycles needed
	typedef logic [4:0] bw_t;

	// horizontal window, 88 clocks of blank ahead of the border
	localparam logic [8:0] HP_BEG [0:3] = '{9'd140, 9'd108, 9'd108, 9'd88};
	localparam logic [8:0] HP_END [0:3] = '{9'd396, 9'd428, 9'd428, 9'd448};

	// vertical window, 192/200/240/288 lines at 50 hz
	localparam logic [8:0] VP_BEG_50 [0:3] = '{9'd80, 9'd76, 9'd56, 9'd32};
	localparam logic [8:0] VP_END_50 [0:3] = '{9'd272, 9'd276, 9'd296, 9'd320};
	// 60 hz caps the 360 mode at 240 lines
	localparam logic [8:0] VP_BEG_60 [0:3] = '{9'd46, 9'd42, 9'd22, 9'd22};
	localparam logic [8:0] VP_END_60 [0:3] = '{9'd238, 9'd242, 9'd262, 9'd262};

	localparam logic [5:0] X_TILE [0:3] = '{6'd34, 6'd42, 6'd42, 6'd47}; // tiles per line

	// fetch lead in clocks, indexed by vmode_t
	localparam logic [4:0] GO_OFFS [0:3] = '{5'd18, 5'd6, 5'd4, 5'd10};

	// 1 of 8, 1 of 4, 1 of 2, 4 of 8
	localparam bw_t MODE_BW [0:3] = '{5'b11_001, 5'b01_001, 5'b00_001, 5'b11_100};

endpackage

`default_nettype wire

// ==== hw/vid_geom_if.sv ====
// window geometry bundle from the raster decoder to the scheduler and the top level
`default_nettype none

interface vid_geom_if;

	logic [8:0] hpix_beg;    // normal layer window
	logic [8:0] hpix_end;
	logic [8:0] vpix_beg;
	logic [8:0] vpix_end;
	logic [8:0] hpix_beg_ts; // tile layer window
	logic [8:0] hpix_end_ts;
	logic [8:0] vpix_beg_ts;
	logic [8:0] vpix_end_ts;
	logic [5:0] x_tiles;

	modport src (output hpix_beg, hpix_end, vpix_beg, vpix_end,
		hpix_beg_ts, hpix_end_ts, vpix_beg_ts, vpix_end_ts, x_tiles);

	modport snk (input hpix_beg, hpix_end, vpix_beg, vpix_end,
		hpix_beg_ts, hpix_end_ts, vpix_beg_ts, vpix_end_ts, x_tiles);

endinterface

`default_nettype wire

// ==== hw/vid_fetch_if.sv ====
// fetch word bundle from the address generator to the scheduler
`default_nettype none

interface vid_fetch_if;

	logic [video_pkg::VADDR_W-1:0] addr; // dram word address
	logic [3:0]                    sel;  // byte lane select
	logic [1:0]                    bsl;  // bit slice select
	video_pkg::bw_t                bw;   // bandwidth code

	modport src (output addr, sel, bsl, bw);

	modport snk (input addr, sel, bsl, bw);

endinterface

`default_nettype wire

// ==== hw/video_raster_decode.sv ====
// raster decoder: line-synchronous resolution latch and pixel/tile window lookup
`default_nettype none

module video_raster_decode (
	input  wire                clk,
	input  wire                arst_n,
	input  wire                line_start_s,
	input  video_pkg::rres_t   rres,
	input  wire                v60hz,
	input  wire                ts_rres_ext,
	vid_geom_if.src            geom
);

	video_pkg::rres_t rres_l; // latched at line start
	logic             v60_l;
	logic             ext_l;  // tile layer forced to 360

	video_pkg::rres_t rres_ts; // resolution seen by the tile layer

	logic [8:0] vbeg_n, vend_n; // vertical window, normal layer
	logic [8:0] vbeg_t, vend_t; // vertical window, tile layer

	// config only moves at line start so the window stays put mid-line
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rres_l <= video_pkg::RRES_256;
			v60_l  <= 1'b0;
			ext_l  <= 1'b0;
		end else if (line_start_s) begin
			rres_l <= rres;
			v60_l  <= v60hz;
			ext_l  <= ts_rres_ext;
		end
	end

	assign rres_ts = ext_l ? video_pkg::RRES_360 : rres_l;

	// frame rate picks the vertical table
	always_comb begin
		if (v60_l) begin
			vbeg_n = video_pkg::VP_BEG_60[rres_l];
			vend_n = video_pkg::VP_END_60[rres_l];
			vbeg_t = video_pkg::VP_BEG_60[rres_ts];
			vend_t = video_pkg::VP_END_60[rres_ts];
		end else begin
			vbeg_n = video_pkg::VP_BEG_50[rres_l];
			vend_n = video_pkg::VP_END_50[rres_l];
			vbeg_t = video_pkg::VP_BEG_50[rres_ts];
			vend_t = video_pkg::VP_END_50[rres_ts];
		end
	end

	assign geom.hpix_beg    = video_pkg::HP_BEG[rres_l];
	assign geom.hpix_end    = video_pkg::HP_END[rres_l];
	assign geom.vpix_beg    = vbeg_n;
	assign geom.vpix_end    = vend_n;

	assign geom.hpix_beg_ts = video_pkg::HP_BEG[rres_ts];
	assign geom.hpix_end_ts = video_pkg::HP_END[rres_ts];
	assign geom.vpix_beg_ts = vbeg_t;
	assign geom.vpix_end_ts = vend_t;

	assign geom.x_tiles     = video_pkg::X_TILE[rres_ts]; // same override as tile window

endmodule

`default_nettype wire

// ==== hw/video_addr_gen.sv ====
// address generator: per-mode dram fetch address, lane and slice selects, bandwidth
`default_nettype none

module video_addr_gen (
	input  wire               [7:0]  vpage,
	input  video_pkg::vmode_t        vmode,
	input  wire               [7:0]  cnt_col,
	input  wire               [8:0]  cnt_row,
	input  wire                      cptr,
	input  wire               [15:0] txt_char,
	vid_fetch_if.src                 fetch
);

	logic [11:0] zx_gfx;   // scrambled row order, 6144 byte bitmap
	logic [11:0] zx_atr;   // attributes at 0x1800 of the page
	logic [13:0] tx_word;  // text slot address below the page

	logic [3:0]  tx_sel;
	logic [1:0]  tx_bsl;
	logic [1:0]  slot;

	assign slot   = cnt_col[1:0];
	assign zx_gfx = {cnt_row[7:6], cnt_row[2:0], cnt_row[5:3], cnt_col[4:1]};
	assign zx_atr = {3'b110, cnt_row[7:3], cnt_col[4:1]};

	// text slots: codes, attributes, glyph of low char, glyph of high char
	always_comb begin
		case (slot)
			2'd0:    tx_word = {vpage[0], cnt_row[8:3], 1'b0, cnt_col[7:2]};
			2'd1:    tx_word = {vpage[0], cnt_row[8:3], 1'b1, cnt_col[7:2]};
			2'd2:    tx_word = {~vpage[0], 3'b000, txt_char[7:0], cnt_row[2:1]};
			default: tx_word = {~vpage[0], 3'b000, txt_char[15:8], cnt_row[2:1]};
		endcase
	end

	// column counter is one ahead when the data lands, so selects lead by a slot
	always_comb begin
		case (slot)
			2'd1:    tx_sel = 4'b0011; // char
			2'd2:    tx_sel = 4'b1100; // attr
			2'd3:    tx_sel = 4'b0001; // glyph 0
			default: tx_sel = 4'b0010; // glyph 1
		endcase
		// glyph slots pick the nibble pair by odd/even line
		tx_bsl = (slot == 2'd1 || slot == 2'd2) ? 2'b10 : {2{cnt_row[0]}};
	end

	always_comb begin
		case (vmode)
			video_pkg::M_ZX: begin
				fetch.addr = {vpage, 1'b0, cnt_col[0] ? zx_atr : zx_gfx}; // gfx/attr interleave
				fetch.sel  = {~cptr, ~cptr, cptr, cptr};
				fetch.bsl  = 2'b10;
			end
			video_pkg::M_HC: begin
				fetch.addr = {vpage[7:3], cnt_row, cnt_col[6:0]};
				fetch.sel  = {~cptr, ~cptr, 2'b11};
				fetch.bsl  = 2'b10;
			end
			video_pkg::M_XC: begin
				fetch.addr = {vpage[7:4], cnt_row, cnt_col};
				fetch.sel  = {~cptr, ~cptr, 2'b11};
				fetch.bsl  = 2'b10;
			end
			default: begin
				fetch.addr = {vpage[7:1], tx_word};
				fetch.sel  = tx_sel;
				fetch.bsl  = tx_bsl;
			end
		endcase
	end

	assign fetch.bw = video_pkg::MODE_BW[vmode];

endmodule

`default_nettype wire

// ==== hw/video_fetch_sched.sv ====
// fetch scheduler: pixel and fetch strobes, window-gated registered fetch request
`default_nettype none

module video_fetch_sched (
	input  wire                             clk,
	input  wire                             arst_n,
	input  wire                             f1,
	input  wire                             c3,
	input  wire                             pix_start,
	input  wire                             line_start_s,
	input  video_pkg::vmode_t               vmode,
	input  wire [3:0]                       fetch_cnt,
	input  wire [8:0]                       cnt_row,
	input  wire [8:0]                       gx_offs,
	vid_geom_if.snk                         geom,
	vid_fetch_if.snk                        fetch,
	output logic                            tv_hires,
	output logic                            vga_hires,
	output logic                            pix_stb,
	output logic                            fetch_stb,
	output video_pkg::render_t              render_mode,
	output logic [4:0]                      go_offs,
	output logic [9:0]                      x_offs_mode,
	output logic                            req_valid,
	output logic [video_pkg::VADDR_W-1:0]   req_addr,
	output logic [3:0]                      req_sel,
	output logic [1:0]                      req_bsl
);

	logic cad_hit; // fetch_cnt cadence reached
	logic v_in;    // row inside vertical pixel window
	logic req_go;

	assign tv_hires = (vmode == video_pkg::M_TX); // text only runs at double rate
	assign pix_stb  = tv_hires ? f1 : c3;
	assign go_offs  = video_pkg::GO_OFFS[vmode];

	always_comb begin
		case (vmode)
			video_pkg::M_ZX: render_mode = video_pkg::R_ZX;
			video_pkg::M_HC: render_mode = video_pkg::R_HC;
			video_pkg::M_XC: render_mode = video_pkg::R_XC;
			default:         render_mode = video_pkg::R_TX;
		endcase
	end

	// one fetch per 16, 4, 2, 16 steps
	always_comb begin
		case (render_mode)
			video_pkg::R_HC: cad_hit = &fetch_cnt[1:0];
			video_pkg::R_XC: cad_hit = fetch_cnt[0];
			default:         cad_hit = &fetch_cnt;
		endcase
	end

	assign fetch_stb = c3 & (pix_start | cad_hit);

	// 256c scrolls in double steps, others in half steps, lsb kept
	assign x_offs_mode = {(vmode == video_pkg::M_XC) ? {gx_offs[8:1], 1'b0} : {1'b0, gx_offs[8:1]},
		gx_offs[0]};

	assign v_in   = (cnt_row >= geom.vpix_beg) && (cnt_row < geom.vpix_end); // end excluded
	assign req_go = fetch_stb & v_in;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vga_hires <= 1'b0;
			req_valid <= 1'b0;
		end else begin
			if (line_start_s)
				vga_hires <= tv_hires; // vga side switches rate per line
			req_valid <= req_go;      // single pulse, no backpressure
		end
	end

	// fetch word captured with the strobe
	always_ff @(posedge clk) begin
		if (req_go) begin
			req_addr <= fetch.addr;
			req_sel  <= fetch.sel;
			req_bsl  <= fetch.bsl;
		end
	end

endmodule

`default_nettype wire

// ==== hw/video_mode_top.sv ====
// video mode decoder top level: raster decoder, address generator and fetch scheduler
`default_nettype none

module video_mode_top (
	input  wire                           clk,
	input  wire                           arst_n,
	input  wire                           f1,
	input  wire                           c3,
	input  wire                           pix_start,
	input  wire                           line_start_s,
	input  wire [7:0]                     vconf,
	input  wire [7:0]                     vpage,
	input  wire                           v60hz,
	input  wire                           ts_rres_ext,
	input  wire [3:0]                     fetch_cnt,
	input  wire [7:0]                     cnt_col,
	input  wire [8:0]                     cnt_row,
	input  wire                           cptr,
	input  wire [15:0]                    txt_char,
	input  wire [8:0]                     gx_offs,
	output logic [8:0]                    hpix_beg,
	output logic [8:0]                    hpix_end,
	output logic [8:0]                    vpix_beg,
	output logic [8:0]                    vpix_end,
	output logic [8:0]                    hpix_beg_ts,
	output logic [8:0]                    hpix_end_ts,
	output logic [8:0]                    vpix_beg_ts,
	output logic [8:0]                    vpix_end_ts,
	output logic [5:0]                    x_tiles,
	output logic [3:0]                    fetch_sel,
	output logic [1:0]                    fetch_bsl,
	output logic [video_pkg::VADDR_W-1:0] video_addr,
	output video_pkg::bw_t                video_bw,
	output logic                          tv_hires,
	output logic                          vga_hires,
	output logic                          pix_stb,
	output logic                          fetch_stb,
	output video_pkg::render_t            render_mode,
	output logic [4:0]                    go_offs,
	output logic [9:0]                    x_offs_mode,
	output logic                          req_valid,
	output logic [video_pkg::VADDR_W-1:0] req_addr,
	output logic [3:0]                    req_sel,
	output logic [1:0]                    req_bsl
);

	video_pkg::vmode_t vmode;
	video_pkg::rres_t  rres;

	assign vmode = video_pkg::vmode_t'(vconf[1:0]);
	assign rres  = video_pkg::rres_t'(vconf[7:6]);

	vid_geom_if  geom_if ();
	vid_fetch_if fetch_if ();

	video_raster_decode i_raster (.clk(clk), .arst_n(arst_n), .line_start_s(line_start_s),
		.rres(rres), .v60hz(v60hz), .ts_rres_ext(ts_rres_ext), .geom(geom_if.src));

	video_addr_gen i_addr (.vpage(vpage), .vmode(vmode), .cnt_col(cnt_col), .cnt_row(cnt_row),
		.cptr(cptr), .txt_char(txt_char), .fetch(fetch_if.src));

	video_fetch_sched i_sched (.clk(clk), .arst_n(arst_n), .f1(f1), .c3(c3),
		.pix_start(pix_start), .line_start_s(line_start_s), .vmode(vmode),
		.fetch_cnt(fetch_cnt), .cnt_row(cnt_row), .gx_offs(gx_offs),
		.geom(geom_if.snk), .fetch(fetch_if.snk), .tv_hires(tv_hires),
		.vga_hires(vga_hires), .pix_stb(pix_stb), .fetch_stb(fetch_stb),
		.render_mode(render_mode), .go_offs(go_offs), .x_offs_mode(x_offs_mode),
		.req_valid(req_valid), .req_addr(req_addr), .req_sel(req_sel), .req_bsl(req_bsl));

	// geometry out to renderer and tile layer
	assign hpix_beg    = geom_if.hpix_beg;
	assign hpix_end    = geom_if.hpix_end;
	assign vpix_beg    = geom_if.vpix_beg;
	assign vpix_end    = geom_if.vpix_end;
	assign hpix_beg_ts = geom_if.hpix_beg_ts;
	assign hpix_end_ts = geom_if.hpix_end_ts;
	assign vpix_beg_ts = geom_if.vpix_beg_ts;
	assign vpix_end_ts = geom_if.vpix_end_ts;
	assign x_tiles     = geom_if.x_tiles;

	// live fetch word to the dram arbiter
	assign video_addr = fetch_if.addr;
	assign fetch_sel  = fetch_if.sel;
	assign fetch_bsl  = fetch_if.bsl;
	assign video_bw   = fetch_if.bw;

endmodule

`default_nettype wire

// ==== verif/video_mode_checker.sv ====
// video mode checker that models the decoder and compares the DUT ports every cycle
`default_nettype none

module video_mode_checker (
	input  wire        clk, arst_n, f1, c3, pix_start, line_start_s,
	input  wire  [7:0] vconf, vpage, cnt_col,
	input  wire        v60hz, ts_rres_ext, cptr,
	input  wire  [3:0] fetch_cnt,
	input  wire  [8:0] cnt_row, gx_offs,
	input  wire [15:0] txt_char,
	input  wire  [8:0] hpix_beg, hpix_end, vpix_beg, vpix_end,
	input  wire  [8:0] hpix_beg_ts, hpix_end_ts, vpix_beg_ts, vpix_end_ts,
	input  wire  [5:0] x_tiles,
	input  wire  [3:0] fetch_sel, req_sel,
	input  wire  [1:0] fetch_bsl, req_bsl, render_mode,
	input  wire [20:0] video_addr, req_addr,
	input  wire  [4:0] video_bw, go_offs,
	input  wire        tv_hires, vga_hires, pix_stb, fetch_stb, req_valid,
	input  wire  [9:0] x_offs_mode,
	output int         err_cnt,
	output int         chk_cnt
);
	timeunit 1ns;
	timeprecision 1ns;

	logic [1:0]  m_rres; // config as seen at the last line start
	logic        m_v60;
	logic        m_ext;
	logic        m_vga;
	logic        m_req;  // request expected this cycle
	logic [26:0] m_word; // {addr, sel, bsl} taken at the strobe

	initial begin
		err_cnt = 0;
		chk_cnt = 0;
	end

	function automatic logic [8:0] vbeg_ref(input logic [1:0] r, input logic v60);
		return v60 ? video_pkg::VP_BEG_60[r] : video_pkg::VP_BEG_50[r];
	endfunction

	function automatic logic [8:0] vend_ref(input logic [1:0] r, input logic v60);
		return v60 ? video_pkg::VP_END_60[r] : video_pkg::VP_END_50[r];
	endfunction

	// fetch lead in clocks per mode
	function automatic logic [4:0] offs_ref(input logic [1:0] m);
		case (m)
			2'd0:    return 5'd18;
			2'd1:    return 5'd6;
			2'd2:    return 5'd4;
			default: return 5'd10;
		endcase
	endfunction

	// dram share as cycles needed out of a slot of 2, 4 or 8
	function automatic logic [4:0] bw_ref(input logic [1:0] m);
		int total;
		int need;
		total = (m == 2'd1) ? 4 : (m == 2'd2) ? 2 : 8;
		need  = (m == 2'd3) ? 4 : 1; // text takes codes, attrs and two glyphs
		return {(total == 8) ? 2'b11 : (total == 4) ? 2'b01 : 2'b00, 3'(need)};
	endfunction

	// expected {addr, sel, bsl} of one fetch
	function automatic logic [26:0] fetch_ref(input logic [1:0] m, input logic [7:0] pg,
		input logic [7:0] col, input logic [8:0] row, input logic cp, input logic [15:0] ch);
		logic [20:0] a;
		logic [3:0]  s;
		logic [1:0]  b;
		b = 2'b10;
		case (m)
			2'd0: begin
				a = 21'(pg) << 13; // 8k page
				if (col[0])
					a += 21'h0c00 + (21'(row[7:3]) << 4) + 21'(col[4:1]); // attr area
				else
					a += (21'(row[7:6]) << 10) + (21'(row[2:0]) << 7) + (21'(row[5:3]) << 4)
						+ 21'(col[4:1]); // thirds hold 8 char rows of 8 lines
				s = cp ? 4'b0011 : 4'b1100;
			end
			2'd1: begin
				a = (21'(pg[7:3]) << 16) + (21'(row) << 7) + 21'(col[6:0]);
				s = cp ? 4'b0011 : 4'b1111;
			end
			2'd2: begin
				a = (21'(pg[7:4]) << 17) + (21'(row) << 8) + 21'(col);
				s = cp ? 4'b0011 : 4'b1111;
			end
			default: begin
				a = 21'(pg[7:1]) << 14;
				case (col[1:0])
					2'd0: begin
						a += (21'(pg[0]) << 13) + (21'(row[8:3]) << 7) + 21'(col[7:2]);
						s = 4'b0010;
					end
					2'd1: begin
						a += (21'(pg[0]) << 13) + (21'(row[8:3]) << 7) + 21'd64 + 21'(col[7:2]);
						s = 4'b0011;
					end
					2'd2: begin
						a += (21'(!pg[0]) << 13) + (21'(ch[7:0]) << 2) + 21'(row[2:1]);
						s = 4'b1100;
					end
					default: begin
						a += (21'(!pg[0]) << 13) + (21'(ch[15:8]) << 2) + 21'(row[2:1]);
						s = 4'b0001;
					end
				endcase
				if (col[1:0] == 2'd0 || col[1:0] == 2'd3)
					b = {row[0], row[0]}; // glyph lines pick odd or even slice
			end
		endcase
		return {a, s, b};
	endfunction

	function automatic logic stb_ref(input logic [1:0] m, input logic c, input logic ps,
		input logic [3:0] fc);
		logic cad;
		case (m)
			2'd1:    cad = (fc % 4) == 3;
			2'd2:    cad = (fc % 2) == 1;
			default: cad = (fc == 4'd15); // zx and text fetch every 16
		endcase
		return c && (ps || cad);
	endfunction

	task automatic cmp(input string name, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %s exp=%h act=%h at %0t", name, exp, act, $time);
		end
	endtask

	always @(posedge clk) begin : compare
		logic [1:0]  rts;
		logic [26:0] w;
		if (!arst_n) begin
			m_rres = 2'd0;
			m_v60  = 1'b0;
			m_ext  = 1'b0;
			m_vga  = 1'b0;
			m_req  = 1'b0;
		end else begin
			// window from the config latched before this edge
			m_req = stb_ref(vconf[1:0], c3, pix_start, fetch_cnt)
				&& cnt_row >= vbeg_ref(m_rres, m_v60) && cnt_row < vend_ref(m_rres, m_v60);
			if (m_req)
				m_word = fetch_ref(vconf[1:0], vpage, cnt_col, cnt_row, cptr, txt_char);
			if (line_start_s) begin
				m_rres = vconf[7:6];
				m_v60  = v60hz;
				m_ext  = ts_rres_ext;
				m_vga  = (vconf[1:0] == 2'd3);
			end
		end
		#5; // mid high phase with registers settled and inputs still held
		rts = m_ext ? 2'd3 : m_rres;
		w   = fetch_ref(vconf[1:0], vpage, cnt_col, cnt_row, cptr, txt_char);
		cmp("hpix_beg", video_pkg::HP_BEG[m_rres], hpix_beg);
		cmp("hpix_end", video_pkg::HP_END[m_rres], hpix_end);
		cmp("vpix_beg", vbeg_ref(m_rres, m_v60), vpix_beg);
		cmp("vpix_end", vend_ref(m_rres, m_v60), vpix_end);
		cmp("hpix_beg_ts", video_pkg::HP_BEG[rts], hpix_beg_ts);
		cmp("hpix_end_ts", video_pkg::HP_END[rts], hpix_end_ts);
		cmp("vpix_beg_ts", vbeg_ref(rts, m_v60), vpix_beg_ts);
		cmp("vpix_end_ts", vend_ref(rts, m_v60), vpix_end_ts);
		cmp("x_tiles", video_pkg::X_TILE[rts], x_tiles);
		cmp("video_addr", w[26:6], video_addr);
		cmp("fetch_sel", w[5:2], fetch_sel);
		cmp("fetch_bsl", w[1:0], fetch_bsl);
		cmp("video_bw", bw_ref(vconf[1:0]), video_bw);
		cmp("tv_hires", vconf[1:0] == 2'd3, tv_hires);
		cmp("pix_stb", (vconf[1:0] == 2'd3) ? f1 : c3, pix_stb);
		cmp("fetch_stb", stb_ref(vconf[1:0], c3, pix_start, fetch_cnt), fetch_stb);
		cmp("render_mode", vconf[1:0], render_mode);
		cmp("go_offs", offs_ref(vconf[1:0]), go_offs);
		cmp("x_offs_mode", (vconf[1:0] == 2'd2) ? ((10'(gx_offs) >> 1) << 2) | 10'(gx_offs[0])
			: 10'(gx_offs), x_offs_mode); // 256c steps doubled
		cmp("vga_hires", m_vga, vga_hires);
		cmp("req_valid", m_req, req_valid);
		if (m_req) begin // fields hold the word from the strobe
			cmp("req_addr", m_word[26:6], req_addr);
			cmp("req_sel", m_word[5:2], req_sel);
			cmp("req_bsl", m_word[1:0], req_bsl);
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_video_mode.sv ====
// video mode decoder testbench with clock, reset, random stimulus and run control
`default_nettype none

module tb_video_mode;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int N_CYC = 3000;             // random stimulus cycles
	localparam int LIMIT = 4 * (N_CYC + 8); // reset and drain included

	logic        clk, arst_n, f1, c3, pix_start, line_start_s;
	logic  [7:0] vconf, vpage, cnt_col;
	logic        v60hz, ts_rres_ext, cptr;
	logic  [3:0] fetch_cnt;
	logic  [8:0] cnt_row, gx_offs;
	logic [15:0] txt_char;
	logic  [8:0] hpix_beg, hpix_end, vpix_beg, vpix_end;
	logic  [8:0] hpix_beg_ts, hpix_end_ts, vpix_beg_ts, vpix_end_ts;
	logic  [5:0] x_tiles;
	logic  [3:0] fetch_sel, req_sel;
	logic  [1:0] fetch_bsl, req_bsl, render_mode;
	logic [20:0] video_addr, req_addr;
	logic  [4:0] video_bw, go_offs;
	logic        tv_hires, vga_hires, pix_stb, fetch_stb, req_valid;
	logic  [9:0] x_offs_mode;
	int          err_cnt, chk_cnt;
	int          cyc = 0;
	logic [31:0] seed;
	logic  [1:0] div; // free-running strobe divider

	video_mode_top i_dut (.*);

	video_mode_checker i_chk (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_bits(output logic [15:0] v);
		seed = lcg_next(seed);
		v    = seed[31:16]; // upper half since low lcg bits repeat fast
	endtask

	task automatic drive_inputs();
		logic [15:0] r;
		div = div + 2'd1;
		f1  = div[0];         // double rate pixel strobe
		c3  = (div == 2'd3);  // one in four
		draw_bits(r);
		vpage   = r[7:0];
		cnt_col = r[15:8];
		draw_bits(r);
		txt_char = r;
		draw_bits(r);
		cnt_row   = r[8:0]; // spans inside and outside every window
		fetch_cnt = r[12:9];
		cptr      = r[13];
		pix_start = (r[15:14] == 2'd0);
		draw_bits(r);
		gx_offs      = r[8:0];
		line_start_s = (r[11:9] == 3'd0); // rare so config changes mid line
		v60hz        = r[12];
		ts_rres_ext  = r[13];
		draw_bits(r);
		vconf = r[7:0];
		// a quarter of the rows land on an edge of the latched window
		case (r[11:8])
			4'd0:    cnt_row = vpix_beg;        // first row inside
			4'd1:    cnt_row = vpix_beg - 9'd1; // last row above
			4'd2:    cnt_row = vpix_end - 9'd1; // last row inside
			4'd3:    cnt_row = vpix_end;        // first row below
			default: ;
		endcase
	endtask

	initial begin
		arst_n       = 1'b0;
		{f1, c3, pix_start, line_start_s} = 4'b0;
		{vconf, vpage, cnt_col} = '0;
		{v60hz, ts_rres_ext, cptr} = 3'b0;
		fetch_cnt    = '0;
		cnt_row      = '0;
		gx_offs      = '0;
		txt_char     = '0;
		seed         = 32'hf3da53aa;
		div          = '0;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		repeat (N_CYC) begin
			@(negedge clk);
			drive_inputs();
		end
		repeat (2) @(posedge clk);
		#6; // last compare done
		$display("checks %0d errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0 && chk_cnt > 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	always @(posedge clk) begin
		cyc++;
		if (cyc >= LIMIT) begin
			$display("timeout: stimulus did not finish within %0d cycles", LIMIT);
			$display("checks %0d errors %0d", chk_cnt, err_cnt);
			$display("Result: FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/video_pkg.sv
hw/vid_geom_if.sv
hw/vid_fetch_if.sv
hw/video_raster_decode.sv
hw/video_addr_gen.sv
hw/video_fetch_sched.sv
hw/video_mode_top.sv
verif/video_mode_checker.sv
verif/tb_video_mode.sv

// ==== Bender.yml ====
package:
  name: video_mode

sources:
  - hw/video_pkg.sv
  - hw/vid_geom_if.sv
  - hw/vid_fetch_if.sv
  - hw/video_raster_decode.sv
  - hw/video_addr_gen.sv
  - hw/video_fetch_sched.sv
  - hw/video_mode_top.sv
  - target: test
    files:
      - verif/video_mode_checker.sv
      - verif/tb_video_mode.sv
